/* logic/decode_cfg.svh */
// ###################################################################
// decode config: datapath widths and fixed constants of the decoder
// ###################################################################
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// data and instruction words
`define XLEN 64
`define ILEN 32

// register index and shift amount fields
`define RIDX_W 5
`define SHAMT_W 6

// pc step for one instruction
`define INST_BYTES 4

`endif

/* logic/decode_pkg.sv */
// ###################################################################
// decode package: word types, format and micro-op enums, stage payloads
// ###################################################################
`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [`ILEN-1:0] inst_t;
  typedef logic [`RIDX_W-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J
  } inst_fmt_e;

  // one value per kept RV64I instruction
  typedef enum logic [5:0] {
    UOP_LUI, UOP_AUIPC, UOP_JAL, UOP_JALR,
    UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
    UOP_LB, UOP_LH, UOP_LW, UOP_LD, UOP_LBU, UOP_LHU, UOP_LWU,
    UOP_SB, UOP_SH, UOP_SW, UOP_SD,
    UOP_ADDI, UOP_SLTI, UOP_SLTIU, UOP_XORI, UOP_ORI, UOP_ANDI,
    UOP_SLLI, UOP_SRLI, UOP_SRAI,
    UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU,
    UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
    UOP_ADDIW, UOP_SLLIW, UOP_SRLIW, UOP_SRAIW,
    UOP_ADDW, UOP_SUBW, UOP_SLLW, UOP_SRLW, UOP_SRAW,
    UOP_ILLEGAL
  } uop_e;

  // raw instruction with its register reads
  typedef struct packed {
    inst_t inst;
    xlen_t pc;
    xlen_t rs1_data;
    xlen_t rs2_data;
  } fetch_pkt_t;

  // decoded instruction ready for execute
  typedef struct packed {
    uop_e     uop;
    reg_idx_t rd;
    logic     rd_wen;
    reg_idx_t rs1;
    logic     rs1_ren;
    reg_idx_t rs2;
    logic     rs2_ren;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    op3;
  } issue_pkt_t;

endpackage

`default_nettype wire

/* logic/decode_if.sv */
// ###################################################################
// classified instruction from classifier to operand select
// ###################################################################
`default_nettype none

interface dec_if;
  import decode_pkg::*;

  uop_e      uop;
  inst_fmt_e fmt;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  logic      rs1_ren;
  logic      rs2_ren;
  logic      rd_wen;
  // sign-extended immediate for the format
  xlen_t     imm;
  xlen_t     pc;

  modport producer (
    output uop, fmt, rs1, rs2, rd, rs1_ren, rs2_ren, rd_wen, imm, pc
  );

  modport consumer (
    input uop, fmt, rs1, rs2, rd, rs1_ren, rs2_ren, rd_wen, imm, pc
  );

endinterface

`default_nettype wire

/* logic/pipe_stage.sv */
// ###################################################################
// pipeline slot: one registered payload with valid/ready handshake
// ###################################################################
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  logic load;

  // slot can take a new item when empty or draining this cycle
  assign o_ready = ~o_valid | i_ready;
  assign load    = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      o_data <= i_data;
    end
  end

endmodule

`default_nettype wire

/* logic/inst_classifier.sv */
// ###################################################################
// instruction classifier: micro-op, format, enables and immediates
// ###################################################################
`default_nettype none

`include "decode_cfg.svh"

module inst_classifier (
  input  decode_pkg::inst_t i_inst,
  input  decode_pkg::xlen_t i_pc,
  dec_if.producer           dec
);
  import decode_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_IMM32  = 7'b0011011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP32   = 7'b0111011;

  logic [6:0]          opcode;
  logic [2:0]          func3;
  logic [6:0]          func7;
  reg_idx_t            rs1;
  reg_idx_t            rs2;
  reg_idx_t            rd;
  logic [`SHAMT_W-1:0] shamt;
  xlen_t               imm_i;
  xlen_t               imm_s;
  xlen_t               imm_b;
  xlen_t               imm_u;
  xlen_t               imm_j;
  uop_e                uop;
  inst_fmt_e           fmt_raw;
  inst_fmt_e           fmt;
  logic                rs1_ren;
  logic                rs2_ren;
  logic                rd_wen;
  logic                w_sh_lo;
  logic                w_sh_hi;

  assign opcode = i_inst[6:0];
  assign rd     = i_inst[11:7];
  assign func3  = i_inst[14:12];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign func7  = i_inst[31:25];
  assign shamt  = i_inst[25:20];

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // word shifts only take a 5-bit shamt
  assign w_sh_lo = (func7[6:1] == 6'b000000) & ~shamt[5];
  assign w_sh_hi = (func7[6:1] == 6'b010000) & ~shamt[5];

  always_comb begin
    uop     = UOP_ILLEGAL;
    fmt_raw = FMT_NONE;
    case (opcode)
      OPC_LUI: begin
        uop     = UOP_LUI;
        fmt_raw = FMT_U;
      end
      OPC_AUIPC: begin
        uop     = UOP_AUIPC;
        fmt_raw = FMT_U;
      end
      OPC_JAL: begin
        uop     = UOP_JAL;
        fmt_raw = FMT_J;
      end
      OPC_JALR: begin
        fmt_raw = FMT_I;
        if (func3 == 3'b000) uop = UOP_JALR;
      end
      OPC_BRANCH: begin
        fmt_raw = FMT_B;
        case (func3)
          3'b000: uop = UOP_BEQ;
          3'b001: uop = UOP_BNE;
          3'b100: uop = UOP_BLT;
          3'b101: uop = UOP_BGE;
          3'b110: uop = UOP_BLTU;
          3'b111: uop = UOP_BGEU;
          default: uop = UOP_ILLEGAL;
        endcase
      end
      OPC_LOAD: begin
        fmt_raw = FMT_I;
        case (func3)
          3'b000: uop = UOP_LB;
          3'b001: uop = UOP_LH;
          3'b010: uop = UOP_LW;
          3'b011: uop = UOP_LD;
          3'b100: uop = UOP_LBU;
          3'b101: uop = UOP_LHU;
          3'b110: uop = UOP_LWU;
          default: uop = UOP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        fmt_raw = FMT_S;
        case (func3)
          3'b000: uop = UOP_SB;
          3'b001: uop = UOP_SH;
          3'b010: uop = UOP_SW;
          3'b011: uop = UOP_SD;
          default: uop = UOP_ILLEGAL;
        endcase
      end
      OPC_IMM: begin
        fmt_raw = FMT_I;
        case (func3)
          3'b000: uop = UOP_ADDI;
          3'b010: uop = UOP_SLTI;
          3'b011: uop = UOP_SLTIU;
          3'b100: uop = UOP_XORI;
          3'b110: uop = UOP_ORI;
          3'b111: uop = UOP_ANDI;
          3'b001: if (func7[6:1] == 6'b000000) uop = UOP_SLLI;
          3'b101: begin
            if (func7[6:1] == 6'b000000) uop = UOP_SRLI;
            else if (func7[6:1] == 6'b010000) uop = UOP_SRAI;
          end
          default: uop = UOP_ILLEGAL;
        endcase
      end
      OPC_IMM32: begin
        fmt_raw = FMT_I;
        if (func3 == 3'b000) uop = UOP_ADDIW;
        else if (func3 == 3'b001 && w_sh_lo) uop = UOP_SLLIW;
        else if (func3 == 3'b101 && w_sh_lo) uop = UOP_SRLIW;
        else if (func3 == 3'b101 && w_sh_hi) uop = UOP_SRAIW;
      end
      OPC_OP: begin
        fmt_raw = FMT_R;
        if (func7 == 7'b0000000) begin
          case (func3)
            3'b000: uop = UOP_ADD;
            3'b001: uop = UOP_SLL;
            3'b010: uop = UOP_SLT;
            3'b011: uop = UOP_SLTU;
            3'b100: uop = UOP_XOR;
            3'b101: uop = UOP_SRL;
            3'b110: uop = UOP_OR;
            default: uop = UOP_AND;
          endcase
        end else if (func7 == 7'b0100000) begin
          if (func3 == 3'b000) uop = UOP_SUB;
          else if (func3 == 3'b101) uop = UOP_SRA;
        end
      end
      OPC_OP32: begin
        fmt_raw = FMT_R;
        if (func7 == 7'b0000000) begin
          if (func3 == 3'b000) uop = UOP_ADDW;
          else if (func3 == 3'b001) uop = UOP_SLLW;
          else if (func3 == 3'b101) uop = UOP_SRLW;
        end else if (func7 == 7'b0100000) begin
          if (func3 == 3'b000) uop = UOP_SUBW;
          else if (func3 == 3'b101) uop = UOP_SRAW;
        end
      end
      default: uop = UOP_ILLEGAL;
    endcase
  end

  // unmatched sub-encodings fall back to no format
  assign fmt = (uop == UOP_ILLEGAL) ? FMT_NONE : fmt_raw;

  assign rs1_ren = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
  assign rs2_ren = fmt inside {FMT_R, FMT_S, FMT_B};
  assign rd_wen  = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};

  always_comb begin
    case (fmt)
      FMT_I: dec.imm = imm_i;
      FMT_S: dec.imm = imm_s;
      FMT_B: dec.imm = imm_b;
      FMT_U: dec.imm = imm_u;
      FMT_J: dec.imm = imm_j;
      default: dec.imm = '0;
    endcase
  end

  assign dec.uop     = uop;
  assign dec.fmt     = fmt;
  assign dec.rs1_ren = rs1_ren;
  assign dec.rs2_ren = rs2_ren;
  assign dec.rd_wen  = rd_wen;
  assign dec.rs1     = rs1_ren ? rs1 : '0;
  assign dec.rs2     = rs2_ren ? rs2 : '0;
  assign dec.rd      = rd_wen ? rd : '0;
  assign dec.pc      = i_pc;

endmodule

`default_nettype wire

/* logic/operand_select.sv */
// ###################################################################
// operand select: forms op1, op2 and op3 for a classified instruction
// ###################################################################
`default_nettype none

`include "decode_cfg.svh"

module operand_select (
  dec_if.consumer                dec,
  input  decode_pkg::xlen_t      i_rs1_data,
  input  decode_pkg::xlen_t      i_rs2_data,
  output decode_pkg::issue_pkt_t o_issue
);
  import decode_pkg::*;

  xlen_t op1;
  xlen_t op2;
  xlen_t op3;
  logic  shift_64;
  logic  shift_32;
  logic  is_load;

  assign shift_64 = dec.uop inside {UOP_SLLI, UOP_SRLI, UOP_SRAI};
  assign shift_32 = dec.uop inside {UOP_SLLIW, UOP_SRLIW, UOP_SRAIW};
  assign is_load  = dec.uop inside {UOP_LB, UOP_LH, UOP_LW, UOP_LD, UOP_LBU, UOP_LHU, UOP_LWU};

  always_comb begin
    case (dec.fmt)
      FMT_R, FMT_I, FMT_S, FMT_B: op1 = i_rs1_data;
      FMT_U: op1 = dec.imm;
      FMT_J: op1 = dec.pc;
      default: op1 = '0;
    endcase
  end

  always_comb begin
    case (dec.fmt)
      FMT_R, FMT_S, FMT_B: op2 = i_rs2_data;
      // link offset
      FMT_J: op2 = xlen_t'(`INST_BYTES);
      FMT_I: begin
        if (shift_64) op2 = {{(`XLEN-`SHAMT_W){1'b0}}, dec.imm[`SHAMT_W-1:0]};
        else if (shift_32) op2 = {{(`XLEN-`SHAMT_W+1){1'b0}}, dec.imm[`SHAMT_W-2:0]};
        else op2 = dec.imm;
      end
      FMT_U: op2 = dec.pc;
      default: op2 = '0;
    endcase
  end

  // branch/jump target, link address or address offset
  always_comb begin
    case (dec.fmt)
      FMT_B, FMT_J: op3 = dec.pc + dec.imm;
      FMT_S: op3 = dec.imm;
      FMT_I: begin
        if (dec.uop == UOP_JALR) op3 = dec.pc + xlen_t'(`INST_BYTES);
        else if (is_load) op3 = dec.imm;
        else op3 = '0;
      end
      default: op3 = '0;
    endcase
  end

  assign o_issue.uop     = dec.uop;
  assign o_issue.rd      = dec.rd;
  assign o_issue.rd_wen  = dec.rd_wen;
  assign o_issue.rs1     = dec.rs1;
  assign o_issue.rs1_ren = dec.rs1_ren;
  assign o_issue.rs2     = dec.rs2;
  assign o_issue.rs2_ren = dec.rs2_ren;
  assign o_issue.op1     = op1;
  assign o_issue.op2     = op2;
  assign o_issue.op3     = op3;

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// ###################################################################
// registered RV64I decode stage, two slots around classify and select
// ###################################################################
`default_nettype none

module decode_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_valid,
  output logic                 o_ready,
  input  decode_pkg::inst_t    i_inst,
  input  decode_pkg::xlen_t    i_pc,
  input  decode_pkg::xlen_t    i_rs1_data,
  input  decode_pkg::xlen_t    i_rs2_data,
  output logic                 o_valid,
  input  logic                 i_ready,
  output decode_pkg::uop_e     o_uop,
  output decode_pkg::reg_idx_t o_rd,
  output logic                 o_rd_wen,
  output decode_pkg::reg_idx_t o_rs1,
  output logic                 o_rs1_ren,
  output decode_pkg::reg_idx_t o_rs2,
  output logic                 o_rs2_ren,
  output decode_pkg::xlen_t    o_op1,
  output decode_pkg::xlen_t    o_op2,
  output decode_pkg::xlen_t    o_op3
);
  import decode_pkg::*;

  fetch_pkt_t fetch_in;
  fetch_pkt_t fetch_q;
  issue_pkt_t issue_d;
  issue_pkt_t issue_q;
  logic       fetch_valid;
  logic       issue_ready;

  dec_if dec ();

  assign fetch_in.inst     = i_inst;
  assign fetch_in.pc       = i_pc;
  assign fetch_in.rs1_data = i_rs1_data;
  assign fetch_in.rs2_data = i_rs2_data;

  // slot A holds the raw instruction
  pipe_stage #(
    .payload_t(fetch_pkt_t)
  ) slot_fetch (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .i_data  (fetch_in),
    .o_valid (fetch_valid),
    .i_ready (issue_ready),
    .o_data  (fetch_q)
  );

  inst_classifier inst_classifier_inst (
    .i_inst (fetch_q.inst),
    .i_pc   (fetch_q.pc),
    .dec    (dec.producer)
  );

  operand_select operand_select_inst (
    .dec        (dec.consumer),
    .i_rs1_data (fetch_q.rs1_data),
    .i_rs2_data (fetch_q.rs2_data),
    .o_issue    (issue_d)
  );

  // slot B presents the decoded result
  pipe_stage #(
    .payload_t(issue_pkt_t)
  ) slot_issue (
    .clk     (clk),
    .rst     (rst),
    .i_valid (fetch_valid),
    .o_ready (issue_ready),
    .i_data  (issue_d),
    .o_valid (o_valid),
    .i_ready (i_ready),
    .o_data  (issue_q)
  );

  assign o_uop     = issue_q.uop;
  assign o_rd      = issue_q.rd;
  assign o_rd_wen  = issue_q.rd_wen;
  assign o_rs1     = issue_q.rs1;
  assign o_rs1_ren = issue_q.rs1_ren;
  assign o_rs2     = issue_q.rs2;
  assign o_rs2_ren = issue_q.rs2_ren;
  assign o_op1     = issue_q.op1;
  assign o_op2     = issue_q.op2;
  assign o_op3     = issue_q.op3;

endmodule

`default_nettype wire

/* test/decode_ref.svh */
// ###################################################################
// reference decoder: encoding table and expected issue fields
// ###################################################################
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

typedef struct packed {
  uop_e     uop;
  reg_idx_t rd;
  logic     rd_wen;
  reg_idx_t rs1;
  logic     rs1_ren;
  reg_idx_t rs2;
  logic     rs2_ren;
  xlen_t    op1;
  xlen_t    op2;
  xlen_t    op3;
} exp_t;

// {mask, value} of the fixed instruction bits
function automatic logic [63:0] fixed_bits(logic [6:0] m7, logic [6:0] f7, logic m3,
                                           logic [2:0] f3, logic [6:0] opc);
  logic [31:0] mask;
  logic [31:0] val;
  mask = {m7, 10'b0, {3{m3}}, 5'b0, 7'h7f};
  val  = {f7 & m7, 10'b0, f3 & {3{m3}}, 5'b0, opc};
  return {mask, val};
endfunction

function automatic logic [63:0] uop_encoding(uop_e u);
  case (u)
    UOP_LUI:   return fixed_bits(7'h00, 7'h00, 1'b0, 3'd0, 7'h37);
    UOP_AUIPC: return fixed_bits(7'h00, 7'h00, 1'b0, 3'd0, 7'h17);
    UOP_JAL:   return fixed_bits(7'h00, 7'h00, 1'b0, 3'd0, 7'h6f);
    UOP_JALR:  return fixed_bits(7'h00, 7'h00, 1'b1, 3'd0, 7'h67);
    UOP_BEQ:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd0, 7'h63);
    UOP_BNE:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd1, 7'h63);
    UOP_BLT:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd4, 7'h63);
    UOP_BGE:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd5, 7'h63);
    UOP_BLTU:  return fixed_bits(7'h00, 7'h00, 1'b1, 3'd6, 7'h63);
    UOP_BGEU:  return fixed_bits(7'h00, 7'h00, 1'b1, 3'd7, 7'h63);
    UOP_LB:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd0, 7'h03);
    UOP_LH:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd1, 7'h03);
    UOP_LW:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd2, 7'h03);
    UOP_LD:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd3, 7'h03);
    UOP_LBU:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd4, 7'h03);
    UOP_LHU:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd5, 7'h03);
    UOP_LWU:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd6, 7'h03);
    UOP_SB:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd0, 7'h23);
    UOP_SH:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd1, 7'h23);
    UOP_SW:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd2, 7'h23);
    UOP_SD:    return fixed_bits(7'h00, 7'h00, 1'b1, 3'd3, 7'h23);
    UOP_ADDI:  return fixed_bits(7'h00, 7'h00, 1'b1, 3'd0, 7'h13);
    UOP_SLTI:  return fixed_bits(7'h00, 7'h00, 1'b1, 3'd2, 7'h13);
    UOP_SLTIU: return fixed_bits(7'h00, 7'h00, 1'b1, 3'd3, 7'h13);
    UOP_XORI:  return fixed_bits(7'h00, 7'h00, 1'b1, 3'd4, 7'h13);
    UOP_ORI:   return fixed_bits(7'h00, 7'h00, 1'b1, 3'd6, 7'h13);
    UOP_ANDI:  return fixed_bits(7'h00, 7'h00, 1'b1, 3'd7, 7'h13);
    // 64-bit shifts leave shamt[5] free
    UOP_SLLI:  return fixed_bits(7'h7e, 7'h00, 1'b1, 3'd1, 7'h13);
    UOP_SRLI:  return fixed_bits(7'h7e, 7'h00, 1'b1, 3'd5, 7'h13);
    UOP_SRAI:  return fixed_bits(7'h7e, 7'h20, 1'b1, 3'd5, 7'h13);
    UOP_ADD:   return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd0, 7'h33);
    UOP_SUB:   return fixed_bits(7'h7f, 7'h20, 1'b1, 3'd0, 7'h33);
    UOP_SLL:   return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd1, 7'h33);
    UOP_SLT:   return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd2, 7'h33);
    UOP_SLTU:  return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd3, 7'h33);
    UOP_XOR:   return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd4, 7'h33);
    UOP_SRL:   return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd5, 7'h33);
    UOP_SRA:   return fixed_bits(7'h7f, 7'h20, 1'b1, 3'd5, 7'h33);
    UOP_OR:    return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd6, 7'h33);
    UOP_AND:   return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd7, 7'h33);
    UOP_ADDIW: return fixed_bits(7'h00, 7'h00, 1'b1, 3'd0, 7'h1b);
    UOP_SLLIW: return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd1, 7'h1b);
    UOP_SRLIW: return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd5, 7'h1b);
    UOP_SRAIW: return fixed_bits(7'h7f, 7'h20, 1'b1, 3'd5, 7'h1b);
    UOP_ADDW:  return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd0, 7'h3b);
    UOP_SUBW:  return fixed_bits(7'h7f, 7'h20, 1'b1, 3'd0, 7'h3b);
    UOP_SLLW:  return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd1, 7'h3b);
    UOP_SRLW:  return fixed_bits(7'h7f, 7'h00, 1'b1, 3'd5, 7'h3b);
    UOP_SRAW:  return fixed_bits(7'h7f, 7'h20, 1'b1, 3'd5, 7'h3b);
    default:   return {32'hffff_ffff, 32'h0000_0000};
  endcase
endfunction

function automatic inst_fmt_e ref_format(uop_e u);
  if (u inside {UOP_LUI, UOP_AUIPC}) return FMT_U;
  if (u == UOP_JAL) return FMT_J;
  if (u inside {UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU}) return FMT_B;
  if (u inside {UOP_SB, UOP_SH, UOP_SW, UOP_SD}) return FMT_S;
  if (u inside {UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU, UOP_XOR, UOP_SRL,
                UOP_SRA, UOP_OR, UOP_AND, UOP_ADDW, UOP_SUBW, UOP_SLLW,
                UOP_SRLW, UOP_SRAW}) return FMT_R;
  if (u == UOP_ILLEGAL) return FMT_NONE;
  return FMT_I;
endfunction

function automatic exp_t ref_decode(uop_e u, inst_t w, xlen_t pc, xlen_t rs1d, xlen_t rs2d);
  exp_t      e;
  inst_fmt_e f;
  xlen_t     imm;
  f = ref_format(u);
  case (f)
    FMT_I: imm = {{52{w[31]}}, w[31:20]};
    FMT_S: imm = {{52{w[31]}}, w[31:25], w[11:7]};
    FMT_B: imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    FMT_U: imm = {{32{w[31]}}, w[31:12], 12'h000};
    FMT_J: imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    default: imm = '0;
  endcase
  e = '0;
  e.uop = u;
  e.rs1_ren = f inside {FMT_R, FMT_I, FMT_S, FMT_B};
  e.rs2_ren = f inside {FMT_R, FMT_S, FMT_B};
  e.rd_wen  = f inside {FMT_R, FMT_I, FMT_U, FMT_J};
  e.rs1 = e.rs1_ren ? w[19:15] : 5'd0;
  e.rs2 = e.rs2_ren ? w[24:20] : 5'd0;
  e.rd  = e.rd_wen ? w[11:7] : 5'd0;
  case (f)
    FMT_R, FMT_I, FMT_S, FMT_B: e.op1 = rs1d;
    FMT_U: e.op1 = imm;
    FMT_J: e.op1 = pc;
    default: e.op1 = '0;
  endcase
  case (f)
    FMT_R, FMT_S, FMT_B: e.op2 = rs2d;
    FMT_J: e.op2 = xlen_t'(`INST_BYTES);
    FMT_U: e.op2 = pc;
    FMT_I: begin
      if (u inside {UOP_SLLI, UOP_SRLI, UOP_SRAI}) e.op2 = {58'b0, w[25:20]};
      else if (u inside {UOP_SLLIW, UOP_SRLIW, UOP_SRAIW}) e.op2 = {59'b0, w[24:20]};
      else e.op2 = imm;
    end
    default: e.op2 = '0;
  endcase
  // target, link address or address offset
  if (f inside {FMT_B, FMT_J}) e.op3 = pc + imm;
  else if (u == UOP_JALR) e.op3 = pc + xlen_t'(`INST_BYTES);
  else if (f == FMT_S || u inside {UOP_LB, UOP_LH, UOP_LW, UOP_LD, UOP_LBU, UOP_LHU, UOP_LWU})
    e.op3 = imm;
  return e;
endfunction

`endif

/* test/decode_tb.sv */
// ###################################################################
// decode stage testbench: random RV64I words against a reference model
// ###################################################################
`default_nettype none

`include "decode_cfg.svh"

module decode_tb;
  import decode_pkg::*;

  `include "decode_ref.svh"

  localparam int NUM_UOPS  = int'(UOP_ILLEGAL);
  localparam int REPS      = 4;
  localparam int NUM_RAND  = 20;
  localparam int NUM_ITEMS = NUM_UOPS * REPS + 4 + NUM_RAND;

  logic     clk;
  logic     rst;
  logic     i_valid;
  logic     o_ready;
  inst_t    i_inst;
  xlen_t    i_pc;
  xlen_t    i_rs1_data;
  xlen_t    i_rs2_data;
  logic     o_valid;
  logic     i_ready;
  uop_e     o_uop;
  reg_idx_t o_rd;
  logic     o_rd_wen;
  reg_idx_t o_rs1;
  logic     o_rs1_ren;
  reg_idx_t o_rs2;
  logic     o_rs2_ren;
  xlen_t    o_op1;
  xlen_t    o_op2;
  xlen_t    o_op3;

  // stimulus table, one entry per instruction
  uop_e  st_uop [NUM_ITEMS];
  inst_t st_inst [NUM_ITEMS];
  xlen_t st_pc [NUM_ITEMS];
  xlen_t st_rs1 [NUM_ITEMS];
  xlen_t st_rs2 [NUM_ITEMS];
  int    n_built = 0;

  exp_t exp_q [$];
  exp_t head;
  int   sent = 0;
  int   recv_cnt = 0;
  int   field_errs = 0;
  int   proto_errs = 0;
  int   state_errs = 0;

  decode_stage decode_stage_inst (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_valid    (o_valid),
    .i_ready    (i_ready),
    .o_uop      (o_uop),
    .o_rd       (o_rd),
    .o_rd_wen   (o_rd_wen),
    .o_rs1      (o_rs1),
    .o_rs1_ren  (o_rs1_ren),
    .o_rs2      (o_rs2),
    .o_rs2_ren  (o_rs2_ren),
    .o_op1      (o_op1),
    .o_op2      (o_op2),
    .o_op3      (o_op3)
  );

  always #50 clk = ~clk;

  task automatic add_item(uop_e u, inst_t w);
    st_uop[n_built]  = u;
    st_inst[n_built] = w;
    st_pc[n_built]   = {$urandom, $urandom};
    st_rs1[n_built]  = {$urandom, $urandom};
    st_rs2[n_built]  = {$urandom, $urandom};
    n_built++;
  endtask

  task automatic build_stimulus();
    int          u;
    int          r;
    logic [63:0] fix;
    for (u = 0; u < NUM_UOPS; u++) begin
      fix = uop_encoding(uop_e'(u));
      for (r = 0; r < REPS; r++) begin
        add_item(uop_e'(u), ($urandom & ~fix[63:32]) | fix[31:0]);
      end
    end
    // csrrw, csrrsi, ecall and fence
    add_item(UOP_ILLEGAL, 32'h3052_9073);
    add_item(UOP_ILLEGAL, 32'h3004_6073);
    add_item(UOP_ILLEGAL, 32'h0000_0073);
    add_item(UOP_ILLEGAL, 32'h0ff0_000f);
    // opcode bit 0 low is never a kept encoding
    for (r = 0; r < NUM_RAND; r++) begin
      add_item(UOP_ILLEGAL, $urandom & 32'hffff_fffe);
    end
  endtask

  task automatic check_field(string name, logic [63:0] got, logic [63:0] want);
    assert (got == want) else begin
      $display("FAIL %s: got %h, expected %h", name, got, want);
      field_errs++;
    end
  endtask

  task automatic check_item(exp_t e);
    check_field("o_uop", 64'(o_uop), 64'(e.uop));
    check_field("o_rd", 64'(o_rd), 64'(e.rd));
    check_field("o_rd_wen", 64'(o_rd_wen), 64'(e.rd_wen));
    check_field("o_rs1", 64'(o_rs1), 64'(e.rs1));
    check_field("o_rs1_ren", 64'(o_rs1_ren), 64'(e.rs1_ren));
    check_field("o_rs2", 64'(o_rs2), 64'(e.rs2));
    check_field("o_rs2_ren", 64'(o_rs2_ren), 64'(e.rs2_ren));
    check_field("o_op1", o_op1, e.op1);
    check_field("o_op2", o_op2, e.op2);
    check_field("o_op3", o_op3, e.op3);
  endtask

  // held until accepted, ready toggles at random
  task automatic drive_next();
    i_ready = ($urandom % 3) != 0;
    if (sent < NUM_ITEMS) begin
      i_valid    = 1'b1;
      i_inst     = st_inst[sent];
      i_pc       = st_pc[sent];
      i_rs1_data = st_rs1[sent];
      i_rs2_data = st_rs2[sent];
    end else begin
      i_valid = 1'b0;
    end
  endtask

  // scoreboard on both handshakes
  always @(posedge clk) begin
    if (!rst) begin
      assert (!(o_valid && sent == 0)) else begin
        $display("output valid before any instruction was accepted");
        proto_errs++;
      end
      if (o_valid && i_ready) begin
        if (exp_q.size() == 0) begin
          $display("output transfer with no instruction outstanding");
          proto_errs++;
        end else begin
          head = exp_q.pop_front();
          check_item(head);
        end
        recv_cnt++;
      end
      if (i_valid && o_ready) begin
        exp_q.push_back(ref_decode(st_uop[sent], st_inst[sent], st_pc[sent],
                                   st_rs1[sent], st_rs2[sent]));
        sent++;
      end
    end
  end

  initial begin
    void'($urandom(11651));
    clk        = 1'b0;
    rst        = 1'b1;
    i_valid    = 1'b0;
    i_ready    = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
    build_stimulus();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!o_valid && o_ready) else begin
      $display("stage not idle and ready after reset");
      state_errs++;
    end
    while (recv_cnt < NUM_ITEMS) begin
      drive_next();
      @(negedge clk);
    end
    i_valid = 1'b0;
    i_ready = 1'b1;
    repeat (4) @(negedge clk);
    assert (exp_q.size() == 0 && !o_valid && sent == NUM_ITEMS) else begin
      $display("items left in flight or not all sent at end of test");
      state_errs++;
    end
    $display("errors: %0d field, %0d protocol, %0d state; %0d of %0d instructions out",
             field_errs, proto_errs, state_errs, recv_cnt, NUM_ITEMS);
    if (field_errs == 0 && proto_errs == 0 && state_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat ((NUM_ITEMS + 8) * 10) @(posedge clk);
    $display("timeout: only %0d of %0d instructions came out", recv_cnt, NUM_ITEMS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
+incdir+test
logic/decode_pkg.sv
logic/decode_if.sv
logic/pipe_stage.sv
logic/inst_classifier.sv
logic/operand_select.sv
logic/decode_stage.sv
test/decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the decode stage testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module decode_tb -o decode_tb_sim \
  && ./obj_dir/decode_tb_sim | tee sim.log \
  || echo "build or simulation did not complete"
grep -q "TEST RESULT: PASS" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
